// ==== riscv_consts.svh ====
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// width of every data word in the execute path.
`define DATA_WIDTH 32

// request tag, carried unchanged from issue to response.
`define TAG_WIDTH 4

`define ALU_OPT_WIDTH 4

// operand source selector and its codes.
`define SRC_SEL_WIDTH 2

// a = rs1, b = rs2, used by R-type and branch compares.
`define SRC_SEL_RS1_2 2'b00

// a = rs1, b = immediate, used by OP-IMM and LUI.
`define SRC_SEL_RS1_IMM 2'b01

// a = pc, b = 4, used for the jump link value.
`define SRC_SEL_PC_4 2'b10

// a = pc, b = immediate, used by AUIPC.
`define SRC_SEL_PC_IMM 2'b11

`endif

// ==== riscv_isa_pkg.sv ====
`include "riscv_consts.svh"

package riscv_isa_pkg;

  // major opcodes handled by the execute stage.
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // ALU operations. branches all run as ALU_SUB.
  typedef enum logic [`ALU_OPT_WIDTH-1:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10  // returns operand b, which is how LUI gets its value.
  } alu_op_e;

  // funct3 of the conditional branches.
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_funct3_e;

endpackage

// ==== riscv_pipe_pkg.sv ====
`include "riscv_consts.svh"

package riscv_pipe_pkg;

  // one issued instruction with its operands.
  typedef struct packed {
    logic [`TAG_WIDTH-1:0]  tag;
    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] instr;
    logic [`DATA_WIDTH-1:0] rs1_val;
    logic [`DATA_WIDTH-1:0] rs2_val;
  } ex_req_t;

  // decoded controls for the execute unit.
  typedef struct packed {
    riscv_isa_pkg::alu_op_e   alu_opt;
    logic [`SRC_SEL_WIDTH-1:0] src_sel;
    logic [2:0]                funct3;
    logic                      branch;  // set only for conditional branches.
    logic [`DATA_WIDTH-1:0]    imm;
  } ex_ctrl_t;

  // ALU operand pair, a sits in the upper half.
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
  } operand_pair_t;

  typedef struct packed {
    logic [`TAG_WIDTH-1:0]  tag;
    logic [`DATA_WIDTH-1:0] result;
    logic                   zero;
  } ex_rsp_t;

endpackage

// ==== riscv_mux.sv ====
// keyed lookup multiplexer.
// each table entry is {key, payload}; keys are expected to be unique.
module riscv_mux #(
  parameter int  NR_KEY  = 2,
  parameter int  KEY_LEN = 1,
  parameter type data_t  = logic [31:0]
) (
  input  logic [KEY_LEN-1:0]                                key,
  input  data_t                                             default_out,
  input  logic [NR_KEY-1:0][KEY_LEN+$bits(data_t)-1:0]      lut,
  output data_t                                             out
);

  localparam int DATA_LEN = $bits(data_t);

  logic hit;

  always_comb begin
    out = default_out;
    hit = 1'b0;
    for (int i = 0; i < NR_KEY; i++) begin
      if (!hit && (lut[i][DATA_LEN +: KEY_LEN] == key)) begin
        out = data_t'(lut[i][DATA_LEN-1:0]);
        hit = 1'b1;  // first match wins, which only matters for duplicate keys.
      end
    end
  end

endmodule

// ==== riscv_ex_alu.sv ====
`include "riscv_consts.svh"

module riscv_ex_alu (
  input  riscv_isa_pkg::alu_op_e   alu_opt,
  input  logic [`DATA_WIDTH-1:0]   alu_a_data,
  input  logic [`DATA_WIDTH-1:0]   alu_b_data,
  output logic [`DATA_WIDTH-1:0]   alu_out_data,
  output logic                     carry_flag,
  output logic                     signed_flag
);

  logic [`DATA_WIDTH:0]   diff;  // one extra bit to catch the borrow.
  logic [4:0]             shamt;

  assign diff  = {1'b0, alu_a_data} - {1'b0, alu_b_data};
  assign shamt = alu_b_data[4:0];

  // borrow of a - b, so set when a < b unsigned.
  assign carry_flag = diff[`DATA_WIDTH];

  // signed overflow of a - b.
  assign signed_flag = (alu_a_data[`DATA_WIDTH-1] != alu_b_data[`DATA_WIDTH-1]) &&
                       (diff[`DATA_WIDTH-1] != alu_a_data[`DATA_WIDTH-1]);

  always_comb begin
    case (alu_opt)
      riscv_isa_pkg::ALU_ADD:    alu_out_data = alu_a_data + alu_b_data;
      riscv_isa_pkg::ALU_SUB:    alu_out_data = diff[`DATA_WIDTH-1:0];
      riscv_isa_pkg::ALU_SLL:    alu_out_data = alu_a_data << shamt;
      riscv_isa_pkg::ALU_SLT: begin
        alu_out_data = {{(`DATA_WIDTH-1){1'b0}},
                        ($signed(alu_a_data) < $signed(alu_b_data))};
      end
      riscv_isa_pkg::ALU_SLTU: begin
        alu_out_data = {{(`DATA_WIDTH-1){1'b0}}, (alu_a_data < alu_b_data)};
      end
      riscv_isa_pkg::ALU_XOR:    alu_out_data = alu_a_data ^ alu_b_data;
      riscv_isa_pkg::ALU_SRL:    alu_out_data = alu_a_data >> shamt;
      riscv_isa_pkg::ALU_SRA:    alu_out_data = $unsigned($signed(alu_a_data) >>> shamt);
      riscv_isa_pkg::ALU_OR:     alu_out_data = alu_a_data | alu_b_data;
      riscv_isa_pkg::ALU_AND:    alu_out_data = alu_a_data & alu_b_data;
      riscv_isa_pkg::ALU_PASS_B: alu_out_data = alu_b_data;
      default:                   alu_out_data = '0;
    endcase
  end

endmodule

// ==== riscv_exu.sv ====
`include "riscv_consts.svh"

module riscv_exu (
  input  logic [`DATA_WIDTH-1:0]      pc,
  input  logic [`DATA_WIDTH-1:0]      src1,
  input  logic [`DATA_WIDTH-1:0]      src2,
  input  logic [`DATA_WIDTH-1:0]      imm,
  input  riscv_pipe_pkg::ex_ctrl_t    ctrl,
  output logic                        zero_flag,
  output logic [`DATA_WIDTH-1:0]      exu_result
);

  riscv_pipe_pkg::operand_pair_t ops;
  logic [`DATA_WIDTH-1:0]        alu_out_data;
  logic                          carry_flag;
  logic                          signed_flag;
  logic                          lt_signed;

  riscv_mux #(
    .NR_KEY  (4),
    .KEY_LEN (`SRC_SEL_WIDTH),
    .data_t  (riscv_pipe_pkg::operand_pair_t)
  ) u_src_mux (
    .key         (ctrl.src_sel),
    .default_out ('0),
    .lut         ({`SRC_SEL_RS1_2,   src1, src2,
                   `SRC_SEL_RS1_IMM, src1, imm,
                   `SRC_SEL_PC_4,    pc,   `DATA_WIDTH'(4),
                   `SRC_SEL_PC_IMM,  pc,   imm}),
    .out         (ops)
  );

  riscv_ex_alu u_alu (
    .alu_opt      (ctrl.alu_opt),
    .alu_a_data   (ops.a),
    .alu_b_data   (ops.b),
    .alu_out_data (alu_out_data),
    .carry_flag   (carry_flag),
    .signed_flag  (signed_flag)
  );

  // a < b signed is the sign of the difference corrected by overflow.
  assign lt_signed = alu_out_data[`DATA_WIDTH-1] ^ signed_flag;

  // for a branch the word collapses to the taken flag in bit 0.
  riscv_mux #(
    .NR_KEY  (6),
    .KEY_LEN (4),
    .data_t  (logic [`DATA_WIDTH-1:0])
  ) u_branch_mux (
    .key         ({ctrl.branch, ctrl.funct3}),
    .default_out (alu_out_data),
    .lut         ({{1'b1, riscv_isa_pkg::BR_BEQ},  {{(`DATA_WIDTH-1){1'b0}}, ~(|alu_out_data)},
                   {1'b1, riscv_isa_pkg::BR_BNE},  {{(`DATA_WIDTH-1){1'b0}}, |alu_out_data},
                   {1'b1, riscv_isa_pkg::BR_BLT},  {{(`DATA_WIDTH-1){1'b0}}, lt_signed},
                   {1'b1, riscv_isa_pkg::BR_BGE},  {{(`DATA_WIDTH-1){1'b0}}, ~lt_signed},
                   {1'b1, riscv_isa_pkg::BR_BLTU}, {{(`DATA_WIDTH-1){1'b0}}, carry_flag},
                   {1'b1, riscv_isa_pkg::BR_BGEU}, {{(`DATA_WIDTH-1){1'b0}}, ~carry_flag}}),
    .out         (exu_result)
  );

  assign zero_flag = ~(|exu_result);

endmodule

// ==== riscv_id_decoder.sv ====
`include "riscv_consts.svh"

module riscv_id_decoder (
  input  logic [`DATA_WIDTH-1:0]    instr,
  output riscv_pipe_pkg::ex_ctrl_t  ctrl
);

  logic [2:0]             funct3;
  logic                   alt;  // instr[30] picks sub and the arithmetic shift.
  logic [`DATA_WIDTH-1:0] imm_i;
  logic [`DATA_WIDTH-1:0] imm_u;
  logic [`DATA_WIDTH-1:0] imm_b;

  assign funct3 = instr[14:12];
  assign alt    = instr[30];

  assign imm_i = {{(`DATA_WIDTH-12){instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{(`DATA_WIDTH-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  // shared by OP and OP-IMM. only the register form has a subtract.
  function automatic riscv_isa_pkg::alu_op_e arith_op(
    input logic [2:0] f3,
    input logic       alt_bit,
    input logic       reg_form
  );
    case (f3)
      3'b000:  arith_op = (reg_form && alt_bit) ? riscv_isa_pkg::ALU_SUB
                                                 : riscv_isa_pkg::ALU_ADD;
      3'b001:  arith_op = riscv_isa_pkg::ALU_SLL;
      3'b010:  arith_op = riscv_isa_pkg::ALU_SLT;
      3'b011:  arith_op = riscv_isa_pkg::ALU_SLTU;
      3'b100:  arith_op = riscv_isa_pkg::ALU_XOR;
      3'b101:  arith_op = alt_bit ? riscv_isa_pkg::ALU_SRA : riscv_isa_pkg::ALU_SRL;
      3'b110:  arith_op = riscv_isa_pkg::ALU_OR;
      default: arith_op = riscv_isa_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl.alu_opt = riscv_isa_pkg::ALU_ADD;
    ctrl.src_sel = `SRC_SEL_RS1_2;
    ctrl.funct3  = funct3;
    ctrl.branch  = 1'b0;
    ctrl.imm     = '0;  // R-type and JAL leave it at zero.

    case (riscv_isa_pkg::opcode_e'(instr[6:0]))
      riscv_isa_pkg::OPC_OP: begin
        ctrl.alu_opt = arith_op(funct3, alt, 1'b1);
      end
      riscv_isa_pkg::OPC_OP_IMM: begin
        ctrl.alu_opt = arith_op(funct3, alt, 1'b0);
        ctrl.src_sel = `SRC_SEL_RS1_IMM;
        ctrl.imm     = imm_i;  // shifts only look at the low five bits.
      end
      riscv_isa_pkg::OPC_LUI: begin
        ctrl.alu_opt = riscv_isa_pkg::ALU_PASS_B;
        ctrl.src_sel = `SRC_SEL_RS1_IMM;
        ctrl.imm     = imm_u;
      end
      riscv_isa_pkg::OPC_AUIPC: begin
        ctrl.src_sel = `SRC_SEL_PC_IMM;
        ctrl.imm     = imm_u;
      end
      riscv_isa_pkg::OPC_JAL: begin
        ctrl.src_sel = `SRC_SEL_PC_4;  // link value only.
      end
      riscv_isa_pkg::OPC_JALR: begin
        ctrl.src_sel = `SRC_SEL_PC_4;
        ctrl.imm     = imm_i;
      end
      riscv_isa_pkg::OPC_BRANCH: begin
        ctrl.alu_opt = riscv_isa_pkg::ALU_SUB;
        ctrl.branch  = 1'b1;
        ctrl.imm     = imm_b;
      end
      default: begin
        // unknown opcodes keep the add of rs1 and rs2.
      end
    endcase
  end

endmodule

// ==== riscv_ex_stage.sv ====
`include "riscv_consts.svh"

module riscv_ex_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  riscv_pipe_pkg::ex_req_t    in_req,
  output logic                       out_valid,
  output riscv_pipe_pkg::ex_rsp_t    out_rsp
);

  riscv_pipe_pkg::ex_ctrl_t dec_ctrl;

  logic                     dec_valid_q;
  riscv_pipe_pkg::ex_req_t  dec_req_q;
  riscv_pipe_pkg::ex_ctrl_t dec_ctrl_q;

  logic                     exe_zero;
  logic [`DATA_WIDTH-1:0]   exe_result;
  riscv_pipe_pkg::ex_rsp_t  exe_rsp;

  logic                     exe_valid_q;
  riscv_pipe_pkg::ex_rsp_t  exe_rsp_q;

  riscv_id_decoder u_decoder (
    .instr (in_req.instr),
    .ctrl  (dec_ctrl)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid_q <= 1'b0;
      exe_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= in_valid;
      exe_valid_q <= dec_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      dec_req_q  <= in_req;
      dec_ctrl_q <= dec_ctrl;
    end
    if (dec_valid_q) exe_rsp_q <= exe_rsp;  // holds the last result during gaps.
  end

  riscv_exu u_exu (
    .pc         (dec_req_q.pc),
    .src1       (dec_req_q.rs1_val),
    .src2       (dec_req_q.rs2_val),
    .imm        (dec_ctrl_q.imm),
    .ctrl       (dec_ctrl_q),
    .zero_flag  (exe_zero),
    .exu_result (exe_result)
  );

  assign exe_rsp.tag    = dec_req_q.tag;  // the tag rides along untouched.
  assign exe_rsp.result = exe_result;
  assign exe_rsp.zero   = exe_zero;

  assign out_valid = exe_valid_q;
  assign out_rsp   = exe_rsp_q;

endmodule

// ==== riscv_ex_props.sv ====
`include "riscv_consts.svh"

module riscv_ex_props (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    in_valid,
  input logic                    out_valid,
  input riscv_pipe_pkg::ex_rsp_t out_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned err_cnt = 0;  // number of failed properties.

  // two register stages between request and response.
  property p_valid_latency;
    @(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 2);
  endproperty

  property p_quiet_in_reset;
    @(posedge clk) !rst_n |-> !out_valid;
  endproperty

  property p_zero_matches;
    @(posedge clk) disable iff (!rst_n)
      out_valid |-> (out_rsp.zero == (out_rsp.result == '0));
  endproperty

  a_valid_latency: assert property (p_valid_latency)
    else begin
      $error("out_valid does not follow in_valid by two cycles");
      err_cnt = err_cnt + 1;
    end

  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else begin
      $error("out_valid is high while reset is asserted");
      err_cnt = err_cnt + 1;
    end

  a_zero_matches: assert property (p_zero_matches)
    else begin
      $error("zero flag disagrees with the result word");
      err_cnt = err_cnt + 1;
    end

endmodule

bind riscv_ex_stage riscv_ex_props u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out_rsp   (out_rsp)
);

// ==== tb_riscv_ex_stage.sv ====
`include "riscv_consts.svh"

module tb_riscv_ex_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam int N_CORNER     = 6;
  localparam int N_RANDOM     = 200;
  localparam int N_REQ        = 19 * N_CORNER + N_RANDOM + 24 + 36 + 16 + 20 + 8;
  localparam int MAX_CYCLES   = N_REQ + 2 * RESET_CYCLES + 100;

  // funct3 of the ten OP forms followed by the nine OP-IMM forms.
  localparam logic [2:0] ARITH_F3 [19] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5,
                                           3'd6, 3'd7, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5,
                                           3'd5, 3'd6, 3'd7};

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    in_valid;
  riscv_pipe_pkg::ex_req_t in_req;
  logic                    out_valid;
  riscv_pipe_pkg::ex_rsp_t out_rsp;

  riscv_pipe_pkg::ex_rsp_t expected_q[$];
  integer                  seed = 11391;
  int                      cycle_cnt = 0;
  int                      pass_cnt = 0;
  int                      fail_cnt = 0;
  logic [`TAG_WIDTH-1:0]   next_tag = '0;
  logic                    iv_d1 = 1'b0;
  logic                    iv_d2 = 1'b0;

  logic [31:0] corner [N_CORNER] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                                     32'h7fff_ffff, 32'h0000_001f};
  // equal, signed less, unsigned less only, overflow crossing both ways, off by one.
  logic [31:0] br_a [6] = '{32'd5, 32'hffff_fffd, 32'd2, 32'h8000_0000, 32'h7fff_ffff,
                            32'h1234_5678};
  logic [31:0] br_b [6] = '{32'd5, 32'd2, 32'hffff_fffe, 32'h7fff_ffff, 32'h8000_0000,
                            32'h1234_5679};
  logic [2:0]  br_f3 [6] = '{riscv_isa_pkg::BR_BEQ, riscv_isa_pkg::BR_BNE,
                             riscv_isa_pkg::BR_BLT, riscv_isa_pkg::BR_BGE,
                             riscv_isa_pkg::BR_BLTU, riscv_isa_pkg::BR_BGEU};

  riscv_ex_stage u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_rsp   (out_rsp)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] arith_ref(input logic [2:0] f3, input logic alt,
                                            input logic reg_form, input logic [31:0] a,
                                            input logic [31:0] b);
    case (f3)
      3'd0:    return (reg_form && alt) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};  // sign decides first.
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return (alt && a[31]) ? ~(~a >> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic riscv_pipe_pkg::ex_rsp_t ref_execute(input riscv_pipe_pkg::ex_req_t req);
    logic [31:0]             a;
    logic [31:0]             b;
    logic [31:0]             imm_i;
    logic [31:0]             imm_u;
    logic [31:0]             res;
    logic [2:0]              f3;
    logic                    taken;
    riscv_pipe_pkg::ex_rsp_t rsp;
    a     = req.rs1_val;
    b     = req.rs2_val;
    f3    = req.instr[14:12];
    imm_i = {{20{req.instr[31]}}, req.instr[31:20]};
    imm_u = {req.instr[31:12], 12'h000};
    taken = 1'b0;
    case (req.instr[6:0])
      7'b0110011:             res = arith_ref(f3, req.instr[30], 1'b1, a, b);
      7'b0010011:             res = arith_ref(f3, req.instr[30], 1'b0, a, imm_i);
      7'b0110111:             res = imm_u;
      7'b0010111:             res = req.pc + imm_u;
      7'b1101111, 7'b1100111: res = req.pc + 32'd4;  // link value of both jumps.
      7'b1100011: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        res = {31'b0, taken};
      end
      default: res = '0;
    endcase
    rsp.tag    = req.tag;
    rsp.result = res;
    rsp.zero   = (res == 32'd0);
    return rsp;
  endfunction

  // b supplies the immediate of the OP-IMM forms. shifts keep only its shamt.
  function automatic logic [31:0] arith_instr(input int idx, input logic [31:0] b);
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    f3  = ARITH_F3[idx];
    alt = (idx == 1 || idx == 7 || idx == 16);
    if (idx < 10) return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    imm = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'b0, b[4:0]} : b[11:0];
    return {imm, 5'd1, f3, 5'd3, 7'b0010011};
  endfunction

  task automatic issue(input logic [31:0] instr, input logic [31:0] pc,
                       input logic [31:0] rs1, input logic [31:0] rs2);
    riscv_pipe_pkg::ex_req_t req;
    req.tag     = next_tag;
    req.pc      = pc;
    req.instr   = instr;
    req.rs1_val = rs1;
    req.rs2_val = rs2;
    next_tag    = next_tag + 1'b1;
    @(posedge clk);
    in_valid <= 1'b1;
    in_req   <= req;
  endtask

  task automatic issue_random_arith();
    int          idx;
    logic [31:0] a;
    logic [31:0] b;
    idx = int'($unsigned($random(seed)) % 19);
    a   = $random(seed);
    b   = $random(seed);
    issue(arith_instr(idx, b), 32'h0, a, b);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic finish_test(input string name, input int fails_before);
    idle(3);
    while (expected_q.size() != 0) @(posedge clk);
    $display("test %s done, %0d failures", name, fail_cnt - fails_before);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (exp === got) pass_cnt = pass_cnt + 1;
    else begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
      fail_cnt = fail_cnt + 1;
    end
  endtask

  // the comparator samples the DUT on the falling edge.
  always @(negedge clk) begin
    riscv_pipe_pkg::ex_rsp_t exp_rsp;
    if (!rst_n) begin
      check_value("out_valid", 32'd0, {31'b0, out_valid});
      iv_d1 = 1'b0;
      iv_d2 = 1'b0;
    end else begin
      check_value("out_valid", {31'b0, iv_d2}, {31'b0, out_valid});
      if (out_valid) begin
        assert (expected_q.size() != 0) begin
          exp_rsp = expected_q.pop_front();
          check_value("out_rsp.tag", 32'(exp_rsp.tag), 32'(out_rsp.tag));
          check_value("out_rsp.result", exp_rsp.result, out_rsp.result);
          check_value("out_rsp.zero", 32'(exp_rsp.zero), 32'(out_rsp.zero));
        end else begin
          $display("ERROR t=%0t a response came out with no request outstanding", $time);
          fail_cnt = fail_cnt + 1;
        end
      end
      if (in_valid) expected_q.push_back(ref_execute(in_req));
      iv_d2 = iv_d1;
      iv_d1 = in_valid;
    end
  end

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    $display("ERROR the run did not finish within %0d cycles", MAX_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int          fails;
    logic [31:0] pc;
    logic [31:0] imm;
    in_valid = 1'b0;
    in_req   = '0;
    rst_n    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    fails = fail_cnt;
    for (int op = 0; op < 19; op++) begin
      for (int i = 0; i < N_CORNER; i++) begin
        issue(arith_instr(op, corner[N_CORNER-1-i]), 32'h0, corner[i], corner[N_CORNER-1-i]);
      end
    end
    for (int n = 0; n < N_RANDOM; n++) issue_random_arith();
    finish_test("arith", fails);

    fails = fail_cnt;
    for (int n = 0; n < 6; n++) begin
      pc  = $random(seed) & 32'hffff_fffc;
      imm = $random(seed);
      issue({imm[31:12], 5'd3, 7'b0110111}, pc, imm, 32'h0);  // rs1 must not leak in.
      issue({imm[31:12], 5'd3, 7'b0010111}, pc, 32'h0, 32'h0);
      issue({imm[31:7], 7'b1101111}, pc, 32'h0, 32'h0);
      issue({imm[31:20], 5'd1, 3'b000, 5'd3, 7'b1100111}, pc, imm, 32'h0);
    end
    finish_test("upper and jump", fails);

    fails = fail_cnt;
    for (int f = 0; f < 6; f++) begin
      for (int i = 0; i < 6; i++) begin
        issue({7'h2a, 5'd2, 5'd1, br_f3[f], 5'h15, 7'b1100011}, 32'h100, br_a[i], br_b[i]);
      end
    end
    finish_test("branch", fails);

    fails = fail_cnt;
    for (int n = 0; n < 16; n++) issue_random_arith();  // sixteen distinct tags in a row.
    finish_test("back to back", fails);

    fails = fail_cnt;
    for (int n = 0; n < 20; n++) begin
      if ($random(seed) & 1) issue_random_arith();
      else idle(1);
    end
    for (int n = 0; n < 4; n++) issue_random_arith();
    @(posedge clk);
    in_valid <= 1'b0;
    #1 rst_n <= 1'b0;  // lands between clock edges with two requests in flight.
    expected_q.delete();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    idle(3);
    for (int n = 0; n < 4; n++) issue_random_arith();
    finish_test("gaps and reset", fails);

    fails = fail_cnt + int'(u_dut.u_props.err_cnt);
    $display("checks passed %0d, failed %0d", pass_cnt, fails);
    if (fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
riscv_isa_pkg.sv
riscv_pipe_pkg.sv
riscv_mux.sv
riscv_ex_alu.sv
riscv_exu.sv
riscv_id_decoder.sv
riscv_ex_stage.sv
riscv_ex_props.sv
tb_riscv_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_riscv_ex_stage -f compile.f -o sim_riscv_ex_stage

# keep running past assertion errors so the testbench can give its verdict.
./obj_dir/sim_riscv_ex_stage +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
